/* hw/rv_pkg.sv */
/*
 * RV32I pipeline shared definitions
 * Word and register index types, opcodes, ALU and branch codes,
 * the instruction word union and the stage register structs
 */
package rv_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_LUI    = 7'b0110111
    } opcode_e;

    // {alt, funct3} for ALU ops, {2'b10, funct3} for branch tests
    typedef enum logic [4:0] {
        ALU_ADD  = 5'b00000,
        ALU_SUB  = 5'b01000,
        ALU_SLL  = 5'b00001,
        ALU_SLT  = 5'b00010,
        ALU_SLTU = 5'b00011,
        ALU_XOR  = 5'b00100,
        ALU_SRL  = 5'b00101,
        ALU_SRA  = 5'b01101,
        ALU_OR   = 5'b00110,
        ALU_AND  = 5'b00111,
        BR_EQ    = 5'b10000,
        BR_NE    = 5'b10001,
        BR_LT    = 5'b10100,
        BR_GE    = 5'b10101,
        BR_LTU   = 5'b10110,
        BR_GEU   = 5'b10111
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    use_zero_a;   // LUI adds the immediate to zero
        logic    mem_we;
        logic    mem_re;
        logic    reg_we;
        logic    is_branch;
        logic    is_jal;
    } ctrl_t;

    typedef struct packed {
        instr_u    instr;
        xlen_t     pc;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
        xlen_t     imm;
        reg_addr_t rd;
        ctrl_t     ctrl;
    } id_ex_t;

    typedef struct packed {
        xlen_t     result;
        xlen_t     store_data;
        xlen_t     link;
        reg_addr_t rd;
        ctrl_t     ctrl;
    } ex_mem_t;

    typedef struct packed {
        xlen_t     result;
        reg_addr_t rd;
        logic      reg_we;
    } wb_t;

    typedef struct packed {
        xlen_t addr;
        xlen_t wdata;
        logic  we;
        logic  re;
    } dmem_req_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_EX   = 2'd1,
        FWD_MEM  = 2'd2,
        FWD_WB   = 2'd3
    } fwd_sel_e;

    localparam xlen_t NOP_INSTR = 32'h0000_0013;   // ADDI x0, x0, 0

endpackage

/* hw/rv_fetch.sv */
/*
 * Program counter for the fetch stage
 * Steps by one word per cycle, holds during a load-use stall
 * and loads the resolved target when execute redirects
 */
`timescale 1ns/1ps

module rv_fetch #(
    parameter rv_pkg::xlen_t RESET_ADDR = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          hold_i,
    input  logic          redirect_i,
    input  rv_pkg::xlen_t target_i,
    output rv_pkg::xlen_t pc_o
);
    import rv_pkg::*;

    xlen_t pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_ADDR;
        end else if (redirect_i) begin
            pc <= target_i;          // Redirect wins over hold
        end else if (!hold_i) begin
            pc <= pc + 32'd4;
        end
    end

    assign pc_o = pc;

endmodule

/* hw/rv_decoder.sv */
/*
 * Instruction decoder
 * Turns the IF/ID word into a control word, the immediate and
 * the register indices; unused source indices read back as x0
 */
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::instr_u    instr_i,
    output rv_pkg::ctrl_t     ctrl_o,
    output rv_pkg::xlen_t     imm_o,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o,
    output rv_pkg::reg_addr_t rd_o
);
    import rv_pkg::*;

    logic       use_rs1;
    logic       use_rs2;
    logic       alt;
    logic [2:0] f3;
    logic [6:0] f7;

    assign f3 = instr_i.r.funct3;
    assign f7 = instr_i.r.funct7;

    always_comb begin
        ctrl_o  = '0;
        imm_o   = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        alt     = 1'b0;
        case (instr_i.r.opcode)
            OP_REG: begin
                alt           = f7[5] && (f3 == 3'b000 || f3 == 3'b101);   // SUB, SRA
                ctrl_o.alu_op = alu_op_e'({1'b0, alt, f3});
                ctrl_o.reg_we = 1'b1;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
            end
            OP_IMM: begin
                alt            = f7[5] && (f3 == 3'b101);   // Only SRAI takes funct7
                ctrl_o.alu_op  = alu_op_e'({1'b0, alt, f3});
                ctrl_o.use_imm = 1'b1;
                ctrl_o.reg_we  = 1'b1;
                imm_o          = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};
                use_rs1        = 1'b1;
            end
            OP_LOAD: begin
                ctrl_o.use_imm = 1'b1;
                ctrl_o.mem_re  = 1'b1;
                ctrl_o.reg_we  = 1'b1;
                imm_o          = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};
                use_rs1        = 1'b1;
            end
            OP_STORE: begin
                ctrl_o.use_imm = 1'b1;
                ctrl_o.mem_we  = 1'b1;
                imm_o          = {{20{f7[6]}}, f7, instr_i.r.rd};
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
            end
            OP_BRANCH: begin
                if (f3[2:1] != 2'b01) begin   // funct3 010/011 are not branches
                    ctrl_o.alu_op    = alu_op_e'({2'b10, f3});
                    ctrl_o.is_branch = 1'b1;
                    imm_o   = {{20{f7[6]}}, instr_i.r.rd[0], f7[5:0], instr_i.r.rd[4:1], 1'b0};
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            OP_JAL: begin
                ctrl_o.use_imm = 1'b1;
                ctrl_o.reg_we  = 1'b1;
                ctrl_o.is_jal  = 1'b1;
                imm_o = {{12{f7[6]}}, instr_i.r.rs1, f3, instr_i.r.rs2[0],
                         f7[5:0], instr_i.r.rs2[4:1], 1'b0};
            end
            OP_LUI: begin
                ctrl_o.use_imm    = 1'b1;
                ctrl_o.use_zero_a = 1'b1;
                ctrl_o.reg_we     = 1'b1;
                imm_o = {f7, instr_i.r.rs2, instr_i.r.rs1, f3, 12'b0};
            end
            default: ;   // Unknown opcode does nothing
        endcase
    end

    assign rs1_o = use_rs1 ? instr_i.r.rs1 : '0;
    assign rs2_o = use_rs2 ? instr_i.r.rs2 : '0;
    assign rd_o  = ctrl_o.reg_we ? instr_i.r.rd : '0;

endmodule

/* hw/rv_hazard_unit.sv */
/*
 * Hazard unit
 * Load-use stall, flush on a resolved branch or jump, and the
 * forwarding source for each execute operand
 */
`timescale 1ns/1ps

module rv_hazard_unit (
    input  rv_pkg::reg_addr_t id_rs1_i,
    input  rv_pkg::reg_addr_t id_rs2_i,
    input  rv_pkg::id_ex_t    id_ex_i,
    input  rv_pkg::ex_mem_t   ex_mem_i,
    input  rv_pkg::wb_t       mem_wb_i,
    input  rv_pkg::wb_t       wb_i,
    input  logic              redirect_i,
    output logic              stall_o,
    output logic              flush_o,
    output rv_pkg::fwd_sel_e  fwd_a_o,
    output rv_pkg::fwd_sel_e  fwd_b_o
);
    import rv_pkg::*;

    logic load_use;
    logic uses_rs1;
    logic uses_rs2;

    // Newest producer first; a load still in EX/MEM has no data yet
    function automatic fwd_sel_e pick_src(input reg_addr_t rs, input logic used);
        if (!used || rs == '0)
            return FWD_NONE;
        if (ex_mem_i.ctrl.reg_we && !ex_mem_i.ctrl.mem_re && ex_mem_i.rd == rs)
            return FWD_EX;
        if (mem_wb_i.reg_we && mem_wb_i.rd == rs)
            return FWD_MEM;
        if (wb_i.reg_we && wb_i.rd == rs)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    assign load_use = id_ex_i.ctrl.mem_re && id_ex_i.rd != '0 &&
                      (id_ex_i.rd == id_rs1_i || id_ex_i.rd == id_rs2_i);

    assign flush_o = redirect_i;
    assign stall_o = load_use && !redirect_i;   // Flushed slot needs no stall

    assign uses_rs1 = !(id_ex_i.ctrl.use_zero_a || id_ex_i.ctrl.is_jal);
    assign uses_rs2 = !id_ex_i.ctrl.use_imm || id_ex_i.ctrl.mem_we;   // R-type, branch, store

    always_comb begin
        fwd_a_o = pick_src(id_ex_i.instr.r.rs1, uses_rs1);
        fwd_b_o = pick_src(id_ex_i.instr.r.rs2, uses_rs2);
    end

endmodule

/* hw/rv_regfile.sv */
/*
 * Integer register file
 * Two combinational read ports and one write port, x0 reads zero
 */
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    output rv_pkg::xlen_t     rs1_data_o,
    output rv_pkg::xlen_t     rs2_data_o,
    input  rv_pkg::wb_t       wr_i
);
    import rv_pkg::*;

    xlen_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_i.reg_we && wr_i.rd != '0) begin
            regs[wr_i.rd] <= wr_i.result;
        end
    end

    // Same-cycle write is not bypassed here
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* hw/rv_alu.sv */
/*
 * Integer ALU
 * Arithmetic, logic and shift results, or a 0/1 branch test
 */
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_e op_i,
    input  rv_pkg::xlen_t   a_i,
    input  rv_pkg::xlen_t   b_i,
    output rv_pkg::xlen_t   result_o
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SLT:  result_o = {31'b0, lt_s};
            ALU_SLTU: result_o = {31'b0, lt_u};
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = xlen_t'($signed(a_i) >>> shamt);
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            BR_EQ:    result_o = {31'b0, a_i == b_i};   // Branch tests return taken
            BR_NE:    result_o = {31'b0, a_i != b_i};
            BR_LT:    result_o = {31'b0, lt_s};
            BR_GE:    result_o = {31'b0, !lt_s};
            BR_LTU:   result_o = {31'b0, lt_u};
            BR_GEU:   result_o = {31'b0, !lt_u};
            default:  result_o = '0;
        endcase
    end

endmodule

/* hw/rv_core.sv */
/*
 * RV32I five-stage in-order core
 * Fetch, decode, execute, memory and writeback with forwarding
 * from EX/MEM, MEM/WB and a trailing WB register, a one-bubble
 * load-use stall and a two-slot flush on branches and jumps
 */
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::xlen_t RESET_ADDR = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    output rv_pkg::xlen_t     instr_addr_o,
    input  rv_pkg::xlen_t     instr_i,
    output rv_pkg::dmem_req_t dmem_req_o,
    input  rv_pkg::xlen_t     dmem_rdata_i
);
    import rv_pkg::*;

    xlen_t     pc;
    instr_u    if_id_instr;
    xlen_t     if_id_pc;
    id_ex_t    id_ex, id_ex_next, id_ex_bubble;
    ex_mem_t   ex_mem;
    wb_t       mem_wb, mem_wb_next, wb;
    ctrl_t     dec_ctrl;
    xlen_t     dec_imm;
    reg_addr_t dec_rs1, dec_rs2, dec_rd;
    xlen_t     rs1_data, rs2_data;
    logic      stall, flush;
    fwd_sel_e  fwd_a, fwd_b;
    xlen_t     opnd_a, opnd_b, alu_a, alu_b, alu_result;
    xlen_t     ex_fwd_data, link, branch_target, next_pc;
    logic      taken, redirect;

    function automatic xlen_t fwd_mux(input fwd_sel_e sel, input xlen_t reg_val);
        case (sel)
            FWD_EX:  return ex_fwd_data;
            FWD_MEM: return mem_wb.result;
            FWD_WB:  return wb.result;
            default: return reg_val;
        endcase
    endfunction

    rv_fetch #(.RESET_ADDR(RESET_ADDR)) u_fetch (
        .clk(clk), .rst_n(rst_n), .hold_i(stall), .redirect_i(redirect),
        .target_i(next_pc), .pc_o(pc)
    );

    rv_decoder u_decoder (
        .instr_i(if_id_instr), .ctrl_o(dec_ctrl), .imm_o(dec_imm),
        .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .rs1_i(dec_rs1), .rs2_i(dec_rs2),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .wr_i(mem_wb)
    );

    rv_alu u_alu (.op_i(id_ex.ctrl.alu_op), .a_i(alu_a), .b_i(alu_b), .result_o(alu_result));

    rv_hazard_unit u_hazard (
        .id_rs1_i(dec_rs1), .id_rs2_i(dec_rs2), .id_ex_i(id_ex), .ex_mem_i(ex_mem),
        .mem_wb_i(mem_wb), .wb_i(wb), .redirect_i(redirect), .stall_o(stall),
        .flush_o(flush), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
    );

    assign instr_addr_o = pc;

    always_comb begin
        id_ex_bubble       = '0;
        id_ex_bubble.instr = NOP_INSTR;   // Bubble with reg_we clear
    end

    assign id_ex_next = '{instr: if_id_instr, pc: if_id_pc, rs1_data: rs1_data,
                          rs2_data: rs2_data, imm: dec_imm, rd: dec_rd, ctrl: dec_ctrl};

    // Execute operand muxes and branch resolution
    always_comb begin
        opnd_a = fwd_mux(fwd_a, id_ex.rs1_data);
        opnd_b = fwd_mux(fwd_b, id_ex.rs2_data);
    end

    assign alu_a         = id_ex.ctrl.use_zero_a ? '0 : opnd_a;
    assign alu_b         = id_ex.ctrl.use_imm ? id_ex.imm : opnd_b;
    assign link          = id_ex.pc + 32'd4;
    assign branch_target = id_ex.pc + id_ex.imm;
    assign taken         = id_ex.ctrl.is_jal || (id_ex.ctrl.is_branch && alu_result[0]);
    assign redirect      = id_ex.ctrl.is_jal || id_ex.ctrl.is_branch;   // Taken or not
    assign next_pc       = taken ? branch_target : link;

    // Memory stage
    assign ex_fwd_data = ex_mem.ctrl.is_jal ? ex_mem.link : ex_mem.result;
    assign dmem_req_o  = '{addr: ex_mem.result, wdata: ex_mem.store_data,
                          we: ex_mem.ctrl.mem_we, re: ex_mem.ctrl.mem_re};
    assign mem_wb_next = '{result: ex_mem.ctrl.mem_re ? dmem_rdata_i : ex_fwd_data,
                          rd: ex_mem.rd, reg_we: ex_mem.ctrl.reg_we};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id_instr <= NOP_INSTR;
            if_id_pc    <= RESET_ADDR;
            id_ex       <= id_ex_bubble;
            ex_mem      <= '0;
            mem_wb      <= '0;
            wb          <= '0;
        end else begin
            if (flush) begin
                if_id_instr <= NOP_INSTR;
            end else if (!stall) begin
                if_id_instr <= instr_u'(instr_i);
                if_id_pc    <= pc;
            end
            id_ex  <= (flush || stall) ? id_ex_bubble : id_ex_next;
            ex_mem <= '{result: alu_result, store_data: opnd_b, link: link,
                        rd: id_ex.rd, ctrl: id_ex.ctrl};
            mem_wb <= mem_wb_next;
            wb     <= mem_wb;   // Covers the regfile read-during-write case
        end
    end

endmodule

/* testbench/rv_core_assertions.sv */
/*
 * Port checks for the RV32I core
 * Data strobes never overlap, stay quiet right after reset,
 * and all fetch and data addresses are word aligned
 */
`timescale 1ns/1ps

module rv_core_assertions (
    input logic              clk,
    input logic              rst_n,
    input rv_pkg::xlen_t     instr_addr_i,
    input rv_pkg::dmem_req_t dmem_req_i
);

    int fail_count = 0;

    a_we_re_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_req_i.we && dmem_req_i.re))
        else begin
            $error("Data port write and read strobes are set together");
            fail_count++;
        end

    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !dmem_req_i.we && !dmem_req_i.re)
        else begin
            $error("Data port strobe active in the first cycle after reset");
            fail_count++;
        end

    a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        instr_addr_i[1:0] == 2'b00)
        else begin
            $error("Instruction address is not word aligned");
            fail_count++;
        end

    a_data_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_req_i.we || dmem_req_i.re) |-> dmem_req_i.addr[1:0] == 2'b00)
        else begin
            $error("Data address is not word aligned");
            fail_count++;
        end

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk(clk), .rst_n(rst_n), .instr_addr_i(instr_addr_o), .dmem_req_i(dmem_req_o)
);

/* testbench/tb_rv_core.sv */
/*
 * Testbench for the RV32I five-stage core
 * Builds a random program, runs it on an instruction-set model,
 * then checks the store stream and the final data memory
 */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int PROG_LEN    = 200;
    localparam int WATCHDOG_NS = 4 * PROG_LEN * 10 + 4 * 10;

    logic      clk = 1'b0;
    logic      rst_n;
    xlen_t     instr_addr;
    xlen_t     instr_word = '0;
    dmem_req_t dmem_req;
    xlen_t     dmem_rdata = '0;

    xlen_t imem [0:255];
    xlen_t dmem [0:63];
    xlen_t model_mem [0:63];
    xlen_t exp_addr [$];
    xlen_t exp_data [$];
    int    seed = 32'he2dacf2d;
    int    errors = 0;         // Reset and final memory checks
    int    store_errors = 0;
    int    assert_fails = 0;
    int    stores = 0;
    int    n_expected = 0;

    rv_core #(.RESET_ADDR(32'h0)) dut (
        .clk(clk), .rst_n(rst_n), .instr_addr_o(instr_addr), .instr_i(instr_word),
        .dmem_req_o(dmem_req), .dmem_rdata_i(dmem_rdata)
    );

    always #5 clk = ~clk;

    function automatic int rnd(input int n);
        int r;
        r = $random(seed);
        return int'($unsigned(r) % n);
    endfunction

    function automatic reg_addr_t rreg();
        return 5'(1 + rnd(7));   // x1 to x7
    endfunction

    function automatic logic [11:0] woff();
        return 12'(rnd(64) * 4);
    endfunction

    function automatic xlen_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic xlen_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic xlen_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic xlen_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic xlen_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic build_program();
        int          n;
        int          kind;
        int          skip;
        logic [2:0]  f3;
        logic [11:0] imm;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        for (int k = 0; k < 256; k++)
            imem[k] = NOP_INSTR;
        n = 0;
        while (n < PROG_LEN - 8) begin
            kind = rnd(10);
            rd   = rreg();
            rs1  = rreg();
            f3   = 3'(rnd(8));
            if (kind == 7 && n < PROG_LEN - 10) begin
                imem[n] = enc_i(woff(), 5'd0, 3'b010, rd, OP_LOAD);
                // Consumer right behind the load
                imem[n + 1] = rnd(2) ? enc_s(woff(), rd, 5'd0)
                                     : enc_r(7'h00, 3'b000, rreg(), rd, rreg(), OP_REG);
                n += 2;
            end else if (kind == 9 && n < PROG_LEN - 12) begin
                skip = 1 + rnd(3);
                if (rnd(4) == 0) begin
                    imem[n] = enc_j(21'((skip + 1) * 4), rd);
                end else begin
                    f3      = 3'(rnd(6));
                    f3      = (f3 >= 3'd2) ? f3 + 3'd2 : f3;   // Skip 010 and 011
                    imem[n] = enc_b(13'((skip + 1) * 4), rnd(2) ? rs1 : rreg(), rs1, f3);
                end
                for (int s = 1; s <= skip; s++)
                    imem[n + s] = enc_s(woff(), rreg(), 5'd0);   // Visible if not skipped
                n += skip + 1;
            end else begin
                if (kind == 8) begin
                    imem[n] = enc_s(woff(), rd, 5'd0);
                end else if (kind == 6) begin
                    imem[n] = {20'(rnd(1048576)), rd, OP_LUI};
                end else if (kind >= 4) begin
                    imm     = (f3 == 3'b001 || f3 == 3'b101) ? 12'(rnd(32)) : 12'(rnd(4096));
                    imm     = (f3 == 3'b101 && rnd(2) == 1) ? imm | 12'h400 : imm;
                    imem[n] = enc_i(imm, rs1, f3, rd, OP_IMM);
                end else begin
                    imem[n] = enc_r(((f3 == 3'b000 || f3 == 3'b101) && rnd(2) == 1) ?
                                    7'h20 : 7'h00, f3, rd, rs1, rreg(), OP_REG);
                end
                n++;
            end
        end
        for (int r = 1; r < 8; r++)
            imem[n + r - 1] = enc_s(12'(r * 4), 5'(r), 5'd0);   // Dump x1 to x7
        imem[n + 7] = enc_j(21'd0, 5'd0);
    endtask

    task automatic run_model();
        xlen_t x [0:31];
        xlen_t pc, w, a, b, res, npc, ea;
        xlen_t immi, imms, immb, immj;
        logic  wr;
        logic  done;
        int    steps;
        for (int k = 0; k < 32; k++)
            x[k] = '0;
        for (int k = 0; k < 64; k++)
            model_mem[k] = dmem[k];
        pc    = 32'h0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 4 * PROG_LEN) begin
            w    = imem[pc[9:2]];
            a    = x[w[19:15]];
            b    = x[w[24:20]];
            immi = {{20{w[31]}}, w[31:20]};
            imms = {{20{w[31]}}, w[31:25], w[11:7]};
            immb = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            immj = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            npc  = pc + 32'd4;
            res  = '0;
            wr   = 1'b0;
            case (w[6:0])
                OP_REG: begin
                    res = alu_ref(w[14:12], w[30], a, b);
                    wr  = 1'b1;
                end
                OP_IMM: begin
                    res = alu_ref(w[14:12], w[30] && w[14:12] == 3'b101, a, immi);
                    wr  = 1'b1;
                end
                OP_LUI: begin
                    res = {w[31:12], 12'h000};
                    wr  = 1'b1;
                end
                OP_LOAD: begin
                    ea  = a + immi;
                    res = model_mem[ea[7:2]];
                    wr  = 1'b1;
                end
                OP_STORE: begin
                    ea = a + imms;
                    model_mem[ea[7:2]] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
                OP_BRANCH: begin
                    if (branch_ref(w[14:12], a, b))
                        npc = pc + immb;
                end
                OP_JAL: begin
                    res  = pc + 32'd4;
                    wr   = 1'b1;
                    npc  = pc + immj;
                    done = (immj == '0);   // Jump to itself ends the program
                end
                default: ;
            endcase
            if (wr && w[11:7] != 5'd0)
                x[w[11:7]] = res;
            pc = npc;
            steps++;
        end
    endtask

    task automatic check_store();
        xlen_t ea;
        xlen_t ed;
        assert (exp_addr.size() > 0) else begin
            store_errors++;
            $display("Store at time %0t comes after the last store of the program", $time);
        end
        if (exp_addr.size() > 0) begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            assert (dmem_req.addr == ea && dmem_req.wdata == ed) else begin
                store_errors++;
                $display("error at %0t: store %0d expected [%h] = %h, got [%h] = %h",
                         $time, stores, ea, ed, dmem_req.addr, dmem_req.wdata);
            end
        end
        stores++;
        dmem[dmem_req.addr[7:2]] = dmem_req.wdata;
    endtask

    // Memories answer on the falling edge, after the address settled
    always @(negedge clk) begin
        if (rst_n && dmem_req.we)
            check_store();
        instr_word = imem[instr_addr[9:2]];
        dmem_rdata = dmem_req.re ? dmem[dmem_req.addr[7:2]] : '0;
    end

    initial begin
        rst_n = 1'b0;
        for (int k = 0; k < 64; k++)
            dmem[k] = 32'h9e37_79b9 * xlen_t'(k + 1);
        build_program();
        run_model();
        n_expected = exp_addr.size();
        repeat (4) @(negedge clk);
        assert (instr_addr == 32'h0 && !dmem_req.we && !dmem_req.re) else begin
            errors++;
            $display("error at %0t: reset state addr %h we %b re %b",
                     $time, instr_addr, dmem_req.we, dmem_req.re);
        end
        rst_n = 1'b1;
        while (stores < n_expected)
            @(posedge clk);
        repeat (8) @(posedge clk);   // Room for a stray late store
        for (int k = 0; k < 64; k++) begin
            assert (dmem[k] == model_mem[k]) else begin
                errors++;
                $display("error at %0t: data word %0d expected %h, got %h",
                         $time, k, model_mem[k], dmem[k]);
            end
        end
        assert_fails = dut.u_assertions.fail_count;
        $display("%0d of %0d stores, %0d store errors, %0d other errors, %0d port failures",
                 stores, n_expected, store_errors, errors, assert_fails);
        if (errors == 0 && store_errors == 0 && assert_fails == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the core stopped storing at %0d of %0d stores",
                 WATCHDOG_NS, stores, n_expected);
        $display("Checks failed");
        $finish;
    end

endmodule

/* verilog.f */
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decoder.sv
hw/rv_hazard_unit.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_core.sv
testbench/rv_core_assertions.sv
testbench/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Build and run the RV32I core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tb_rv_core -o sim_tb_rv_core

out=$(./obj_dir/sim_tb_rv_core 2>&1) || true
echo "$out"
echo "$out" | grep -qx "All checks passed"
